// ==== vlog.f ====
hdl/fpuIsaPkg.sv
hdl/fpuCtrlPkg.sv
hdl/fpuDecode.sv
hdl/fpuCtrlPipe.sv
hdl/fpuDivCredit.sv
hdl/fpuCtrl.sv
bench/fpuCtrlTb.sv

// ==== Bender.yml ====
package:
  name: fpu_ctrl

sources:
  - hdl/fpuIsaPkg.sv
  - hdl/fpuCtrlPkg.sv
  - hdl/fpuDecode.sv
  - hdl/fpuCtrlPipe.sv
  - hdl/fpuDivCredit.sv
  - hdl/fpuCtrl.sv
  - target: test
    files:
      - bench/fpuCtrlTb.sv

// ==== bench/fpuCtrlTb.sv ====
`timescale 1ns/1ps

module fpuCtrlTb
  import fpuIsaPkg::*, fpuCtrlPkg::*;
();

  typedef enum int {
    kFlw, kFsw, kFmadd, kFmsub, kFnmsub, kFnmadd, kFadd, kFsub, kFmul,
    kFdiv, kFsqrt, kFeq, kFclass, kBad
  } opKindT;

  logic        clk = 1'b0;
  logic        rstN;
  logic [31:0] instrD;
  roundModeT   frmCsr;
  logic [1:0]  fsStatus;
  logic        stallReq, stallM, stallW, flushE, flushM, flushW, divCreditRet;
  logic        stallE;                       // hazard unit output
  logic        illegalD, xEn, yEn, zEn, divStartE, divHoldE;
  ctrlET       ctrlE;
  ctrlMT       ctrlM;
  ctrlWT       ctrlW;

  // reference model state
  logic [31:0] opInstr;
  ctrlET       opWord, expD, expE;          // expected word rides with instrD
  logic [2:0]  opEn, enD, enE;              // {x, y, z}
  ctrlMT       expM;
  ctrlWT       expW;
  int          mCredits, starts, startsBefore, inFlight;
  logic        mIssued, startNow, chkOn;
  logic        expStart, expHold;
  opKindT      kind;
  logic [2:0]  rm;

  always #2 clk = ~clk;
  assign stallE = stallReq | divHoldE;      // hold request turns into a stall

  fpuCtrl u_fpuCtrl (
    .clk(clk), .rstN(rstN), .instrD(instrD), .frmCsr(frmCsr), .fsStatus(fsStatus),
    .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushM(flushM), .flushW(flushW), .divCreditRet(divCreditRet),
    .illegalD(illegalD), .ctrlE(ctrlE), .xEn(xEn), .yEn(yEn), .zEn(zEn),
    .ctrlM(ctrlM), .ctrlW(ctrlW), .divStartE(divStartE), .divHoldE(divHoldE)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [63:0] expV,
                                input logic [63:0] gotV);
    abortRun($sformatf("MISMATCH %s expected 0x%0h got 0x%0h", name, expV, gotV));
  endtask

  // encode one instruction and predict its decoded word
  task automatic buildOp(input opKindT k, input logic [2:0] r, input logic dbl,
                         input roundModeT csr, input logic [1:0] fs);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] f5;
    logic [2:0] f3;
    logic [6:0] opc;
    rd     = 5'($urandom);
    rs1    = 5'($urandom);
    rs2    = 5'($urandom);
    f5     = 5'($urandom);   // rs3 for fma or imm bits for load/store
    f3     = r;
    opc    = opFp;
    opWord = '0;
    opEn   = 3'b110;
    case (k)
      kFlw, kFsw: begin
        opc              = (k == kFlw) ? opLoadFp : opStoreFp;
        f3               = {2'b01, dbl};   // w or d width
        opWord.fRegWrite = (k == kFlw);
        opWord.resSel    = resStore;
        opEn             = 3'b000;
      end
      kFmadd, kFmsub, kFnmsub, kFnmadd: begin
        opc = (k == kFmadd) ? opMadd :
              (k == kFmsub) ? opMsub :
              (k == kFnmsub) ? opNmsub : opNmadd;
        opWord.opCtrl = 3'(int'(k) - int'(kFmadd));
        opEn          = 3'b111;
      end
      kFadd, kFsub, kFmul: begin
        f5            = 5'(int'(k) - int'(kFadd));
        opWord.opCtrl = (k == kFadd) ? 3'b110 : (k == kFsub) ? 3'b111 : 3'b100;
      end
      kFdiv, kFsqrt: begin
        f5             = (k == kFdiv) ? 5'b00011 : 5'b01011;
        opWord.postSel = postDiv;
        opWord.opCtrl  = {2'b00, k == kFsqrt};
        opWord.divOp   = 1'b1;
        opEn           = (k == kFdiv) ? 3'b110 : 3'b100;   // sqrt has no y
      end
      kFeq: begin
        f5 = 5'b10100;
        f3 = 3'b010;
        opWord.fWriteInt = 1'b1;
        opWord.opCtrl    = 3'b010;
      end
      kFclass: begin
        f5 = 5'b11100;
        f3 = 3'b001;
        rs2 = '0;
        opWord.fWriteInt = 1'b1;
        opWord.resSel    = resStore;
        opEn             = 3'b100;
      end
      default: begin
        f5 = 5'b01100;   // unused funct5
        opWord.illegal = 1'b1;
      end
    endcase
    if (k >= kFmadd && k <= kFsqrt) begin   // arithmetic writes fp through post-process
      opWord.fRegWrite = 1'b1;
      opWord.resSel    = resPost;
      if (k != kFdiv && k != kFsqrt) opWord.postSel = postFma;
    end
    opInstr = {f5, 1'b0, dbl, rs2, rs1, f3, rd, opc};
    if (fs == 2'b00 || opWord.illegal) begin
      opWord         = '0;
      opWord.illegal = 1'b1;
      opEn           = 3'b110;
    end else begin
      opWord.frm = (f3 == 3'b111) ? csr : roundModeT'(f3);   // dyn takes the csr
      opWord.fmt = fpFmtT'(dbl);
    end
    opWord.adr1 = rs1;
    opWord.adr2 = rs2;
    opWord.adr3 = f5;
  endtask

  task automatic issueOp(input opKindT k, input logic [2:0] r, input logic dbl,
                         input roundModeT csr, input logic [1:0] fs);
    buildOp(k, r, dbl, csr, fs);
    @(posedge clk);
    instrD   <= opInstr;
    frmCsr   <= csr;
    fsStatus <= fs;
    expD     <= opWord;
    enD      <= opEn;
    chkOn    <= 1'b1;
  endtask

  task automatic setControls(input logic sE, input logic sM, input logic sW, input logic fE,
                             input logic fM, input logic fW, input logic ret);
    stallReq     <= sE;
    stallM       <= sM;
    stallW       <= sW;
    flushE       <= fE;
    flushM       <= fM;
    flushW       <= fW;
    divCreditRet <= ret;
  endtask

  task automatic waitForHold(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (divHoldE !== level) begin
      if (n == 20) abortRun("timed out waiting for divHoldE to change");
      n++;
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference pipeline and credit model
  //////////////////////////////////////////////////////////////////////

  assign expStart = expE.divOp & ~mIssued & (mCredits != 0);
  assign expHold  = expE.divOp & ~mIssued & (mCredits == 0);

  always @(posedge clk) begin
    if (chkOn) starts += int'(divStartE);   // start seen in the cycle just ended
    if (!rstN) begin
      expE = '0;
      enE = 3'b110;
      expM = '0;
      expW = '0;
      mCredits = divCredits;
      mIssued = 1'b0;
      inFlight = 0;
    end else begin
      startNow = expStart;
      if (flushW) expW = '0;
      else if (!stallW) expW = '{fRegWrite: expM.fRegWrite, resSel: expM.resSel};
      if (flushM) expM = '0;
      else if (!stallM) expM = '{fRegWrite: expE.fRegWrite, fWriteInt: expE.fWriteInt,
                                 resSel: expE.resSel, postSel: expE.postSel, opCtrl: expE.opCtrl,
                                 frm: expE.frm, fmt: expE.fmt, illegal: expE.illegal};
      if (flushE) begin
        expE = '0;
        enE  = 3'b110;   // bubble keeps x and y on
      end else if (!stallE) begin
        expE = expD;
        enE  = enD;
      end else if (mIssued) expE.divOp = 1'b0;
      if (startNow && !divCreditRet) mCredits--;
      else if (!startNow && divCreditRet && mCredits < divCredits) mCredits++;
      mIssued = (!stallE || flushE) ? 1'b0 : (mIssued | startNow);
      // queue slots taken, counted from the starts the DUT really sent
      if (divStartE && !divCreditRet) inFlight++;
      else if (!divStartE && divCreditRet && inFlight > 0) inFlight--;
    end
  end

  always @(negedge clk) begin
    if (chkOn) begin
      assert (illegalD === expD.illegal) else reportMismatch("illegalD", expD.illegal, illegalD);
      assert (ctrlE === expE) else reportMismatch("ctrlE", expE, ctrlE);
      assert ({xEn, yEn, zEn} === enE) else reportMismatch("xyzEn", enE, {xEn, yEn, zEn});
      assert (ctrlM === expM) else reportMismatch("ctrlM", expM, ctrlM);
      assert (ctrlW === expW) else reportMismatch("ctrlW", expW, ctrlW);
      assert (divStartE === expStart) else reportMismatch("divStartE", expStart, divStartE);
      assert (divHoldE === expHold) else reportMismatch("divHoldE", expHold, divHoldE);
      assert (!(divStartE && inFlight >= divCredits))
        else abortRun("divide started with every divider queue slot taken");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h0e1ea181));
    rstN = 1'b0;
    instrD = '0;
    frmCsr = rmNe;
    fsStatus = 2'b11;
    stallReq = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    flushE = 1'b0;
    flushM = 1'b0;
    flushW = 1'b0;
    divCreditRet = 1'b0;
    chkOn = 1'b0;
    starts = 0;
    expD = '0;
    expD.illegal = 1'b1;   // all-zero instruction is no fp op
    enD = 3'b110;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;

    issueOp(kFadd, 3'b000, 1'b0, rmNe, 2'b00);    // fpu off
    issueOp(kBad, 3'b000, 1'b0, rmNe, 2'b11);     // unimplemented
    issueOp(kFadd, 3'b001, 1'b0, rmNe, 2'b11);    // static rm
    issueOp(kFsub, 3'b111, 1'b1, rmUp, 2'b11);    // dyn rm and double
    issueOp(kFmul, 3'b100, 1'b1, rmUp, 2'b01);
    issueOp(kFmadd, 3'b111, 1'b0, rmDn, 2'b11);
    issueOp(kFnmadd, 3'b010, 1'b1, rmDn, 2'b11);
    issueOp(kFlw, 3'b000, 1'b1, rmNe, 2'b11);
    setControls(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);   // hold E and M
    issueOp(kFsw, 3'b000, 1'b0, rmNe, 2'b11);
    setControls(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);   // W holds while M flushes
    issueOp(kFeq, 3'b000, 1'b0, rmNe, 2'b11);
    setControls(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    issueOp(kFclass, 3'b000, 1'b1, rmNe, 2'b11);
    setControls(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

    // three divides against two credits
    starts = 0;
    issueOp(kFdiv, 3'b000, 1'b0, rmNe, 2'b11);
    issueOp(kFdiv, 3'b001, 1'b1, rmNe, 2'b11);
    issueOp(kFdiv, 3'b010, 1'b0, rmNe, 2'b11);
    issueOp(kFadd, 3'b000, 1'b0, rmNe, 2'b11);
    waitForHold(1'b1);
    if (starts != 2)
      abortRun($sformatf("expected 2 divider starts before hold, saw %0d", starts));
    @(posedge clk);
    divCreditRet <= 1'b1;
    @(posedge clk);
    divCreditRet <= 1'b0;
    waitForHold(1'b0);
    repeat (3) @(negedge clk);
    if (starts != 3)
      abortRun($sformatf("expected 3 divider starts after return, saw %0d", starts));

    // refill then hold a divide in E
    @(posedge clk);
    setControls(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    repeat (2) @(posedge clk);
    startsBefore = starts;
    issueOp(kFsqrt, 3'b000, 1'b1, rmNe, 2'b11);
    setControls(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    issueOp(kFadd, 3'b000, 1'b0, rmNe, 2'b11);
    setControls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (4) @(posedge clk);
    stallReq <= 1'b0;
    repeat (3) @(negedge clk);
    if (starts != startsBefore + 1) abortRun("stalled divide did not start exactly once");

    // random mix
    repeat (400) begin
      kind = opKindT'($urandom_range(0, 13));
      rm   = ($urandom_range(0, 5) == 5) ? 3'b111 : 3'($urandom_range(0, 4));
      issueOp(kind, rm, 1'($urandom), roundModeT'($urandom_range(0, 4)),
              ($urandom_range(0, 7) == 0) ? 2'b00 : 2'($urandom_range(1, 3)));
      setControls($urandom_range(0, 3) == 0, $urandom_range(0, 7) == 0,
                  $urandom_range(0, 7) == 0, $urandom_range(0, 15) == 0,
                  $urandom_range(0, 15) == 0, $urandom_range(0, 15) == 0,
                  $urandom_range(0, 3) == 0);
    end
    repeat (2) @(negedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== hdl/fpuCtrl.sv ====
`timescale 1ns/1ps

module fpuCtrl
  import fpuIsaPkg::*, fpuCtrlPkg::*;
(
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instrD,
  input  roundModeT   frmCsr,
  input  logic [1:0]  fsStatus,
  input  logic        stallE, stallM, stallW,
  input  logic        flushE, flushM, flushW,
  input  logic        divCreditRet,
  output logic        illegalD,
  output ctrlET       ctrlE,
  output logic        xEn,
  output logic        yEn,
  output logic        zEn,
  output ctrlMT       ctrlM,
  output ctrlWT       ctrlW,
  output logic        divStartE,
  output logic        divHoldE
);

  ctrlDT ctrlD;
  logic  divIssued;   // credit block -> pipe

  fpuDecode u_fpuDecode (
    .instrD(instrD), .frmCsr(frmCsr), .fsStatus(fsStatus), .ctrlD(ctrlD)
  );

  assign illegalD = ctrlD.illegal;   // same cycle as instrD

  fpuCtrlPipe u_fpuCtrlPipe (
    .clk(clk), .rstN(rstN), .ctrlD(ctrlD), .instrD(instrD),
    .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushM(flushM), .flushW(flushW),
    .divIssued(divIssued),
    .ctrlE(ctrlE), .ctrlM(ctrlM), .ctrlW(ctrlW),
    .xEn(xEn), .yEn(yEn), .zEn(zEn)
  );

  fpuDivCredit u_fpuDivCredit (
    .clk(clk), .rstN(rstN), .ctrlE(ctrlE), .stallE(stallE), .flushE(flushE),
    .divCreditRet(divCreditRet),
    .divStartE(divStartE), .divHoldE(divHoldE), .divIssued(divIssued)
  );

endmodule

// ==== hdl/fpuDivCredit.sv ====
`timescale 1ns/1ps

module fpuDivCredit
  import fpuCtrlPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  ctrlET ctrlE,
  input  logic  stallE,
  input  logic  flushE,
  input  logic  divCreditRet,   // divider freed one queue slot
  output logic  divStartE,
  output logic  divHoldE,       // to hazard unit, becomes stallE
  output logic  divIssued
);

  logic [creditW-1:0] credits;
  logic               issued;    // start sent, E not yet advanced
  logic               pending;   // div in E still waiting to go
  logic               advanceE;

  assign advanceE  = ~stallE | flushE;
  assign pending   = ctrlE.divOp & ~issued;
  assign divStartE = pending & (credits != '0);
  assign divHoldE  = pending & (credits == '0);
  assign divIssued = issued;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      credits <= creditW'(divCredits);   // queue empty
      issued  <= 1'b0;
    end else begin
      issued <= advanceE ? 1'b0 : (issued | divStartE);
      case ({divStartE, divCreditRet})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   if (credits != creditW'(divCredits)) credits <= credits + 1'b1;
        default: credits <= credits;   // none, or start and return cancel
      endcase
    end
  end

endmodule

// ==== hdl/fpuCtrlPipe.sv ====
`timescale 1ns/1ps

module fpuCtrlPipe
  import fpuIsaPkg::*, fpuCtrlPkg::*;
(
  input  logic        clk,
  input  logic        rstN,
  input  ctrlDT       ctrlD,
  input  logic [31:0] instrD,     // operand address fields
  input  logic        stallE, stallM, stallW,
  input  logic        flushE, flushM, flushW,
  input  logic        divIssued,  // start already sent for the word in E
  output ctrlET       ctrlE,
  output ctrlMT       ctrlM,
  output ctrlWT       ctrlW,
  output logic        xEn,
  output logic        yEn,
  output logic        zEn
);

  ctrlET nextE;
  logic  ldStClass;   // load, store or class
  logic  mvToFp;      // fmv.*.x
  logic  cvtPost;     // converter in post-process

  // next E word, addresses straight from the instruction
  always_comb begin
    nextE           = '0;
    nextE.fRegWrite = ctrlD.fRegWrite;
    nextE.fWriteInt = ctrlD.fWriteInt;
    nextE.resSel    = ctrlD.resSel;
    nextE.postSel   = ctrlD.postSel;
    nextE.opCtrl    = ctrlD.opCtrl;
    nextE.illegal   = ctrlD.illegal;
    nextE.frm       = ctrlD.frm;
    nextE.fmt       = ctrlD.fmt;
    nextE.adr1      = instrD[15 +: regAdrW];
    nextE.adr2      = instrD[20 +: regAdrW];
    nextE.adr3      = instrD[27 +: regAdrW];
    nextE.divOp     = ctrlD.divStart;
  end

  ////////////////////////////////////////////////////////////////////
  // pipeline registers, flush beats stall
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN || flushE) ctrlE <= '0;
    else if (!stallE) ctrlE <= nextE;
    else if (divIssued) ctrlE.divOp <= 1'b0;   // held div already started
  end

  always_ff @(posedge clk) begin
    if (!rstN || flushM) begin
      ctrlM <= '0;
    end else if (!stallM) begin
      ctrlM <= '{fRegWrite: ctrlE.fRegWrite, fWriteInt: ctrlE.fWriteInt,
                 resSel: ctrlE.resSel, postSel: ctrlE.postSel, opCtrl: ctrlE.opCtrl,
                 frm: ctrlE.frm, fmt: ctrlE.fmt, illegal: ctrlE.illegal};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN || flushW) ctrlW <= '0;
    else if (!stallW) ctrlW <= '{fRegWrite: ctrlM.fRegWrite, resSel: ctrlM.resSel};
  end

  ////////////////////////////////////////////////////////////////////
  // operand enables, E stage
  ////////////////////////////////////////////////////////////////////

  assign ldStClass = (ctrlE.resSel == resStore);
  assign mvToFp    = (ctrlE.resSel == resOther) & ctrlE.fRegWrite & (ctrlE.opCtrl == 3'b011);
  assign cvtPost   = (ctrlE.resSel == resPost) & (ctrlE.postSel == postCvt);

  // x unused by load/store, fmv to fp and int -> fp
  assign xEn = ~((ldStClass & ~ctrlE.fWriteInt) | mvToFp | (cvtPost & ctrlE.opCtrl[2]));
  // y unused by load/store/class, moves, converts and sqrt
  assign yEn = ~(ldStClass | mvToFp | (ctrlE.resSel == resMove) | cvtPost |
                 ((ctrlE.resSel == resPost) & (ctrlE.postSel == postDiv) & ctrlE.opCtrl[0]));
  // z only for the true fma ops
  assign zEn = (ctrlE.resSel == resPost) & (ctrlE.postSel == postFma) & ~ctrlE.opCtrl[2];

endmodule

// ==== hdl/fpuDecode.sv ====
`timescale 1ns/1ps

module fpuDecode
  import fpuIsaPkg::*, fpuCtrlPkg::*;
(
  input  logic [31:0] instrD,
  input  roundModeT   frmCsr,     // dynamic rounding mode
  input  logic [1:0]  fsStatus,   // mstatus.fs, 00 = fpu off
  output ctrlDT       ctrlD
);

  fpOpcodeT            op;
  fpFunct5T            funct5;
  logic [funct3W-1:0]  funct3;
  logic [1:0]          fmtBits;   // funct7[1:0]
  logic [regAdrW-1:0]  rs2;
  logic                fmtOk;     // single or double
  logic                cvtFF;
  logic                bad;
  ctrlDT               dec;

  // build one control word, frm/fmt filled in later
  function automatic ctrlDT mk(input logic wr, input logic wi, input resSelT rs,
                               input postSelT ps, input logic [2:0] oc, input logic ds);
    ctrlDT w;
    w           = '0;
    w.fRegWrite = wr;
    w.fWriteInt = wi;
    w.resSel    = rs;
    w.postSel   = ps;
    w.opCtrl    = oc;
    w.divStart  = ds;
    return w;
  endfunction

  // field split
  assign op      = fpOpcodeT'(instrD[6:0]);
  assign funct5  = fpFunct5T'(instrD[31:27]);
  assign funct3  = instrD[14:12];
  assign fmtBits = instrD[26:25];
  assign rs2     = instrD[24:20];
  assign fmtOk   = ~fmtBits[1];
  assign cvtFF   = (op == opFp) && (funct5 == f5CvtFF);

  ////////////////////////////////////////////////////////////////////
  // opcode table
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    dec = '0;
    bad = 1'b0;
    case (op)
      opLoadFp:  if (funct3[2:1] == 2'b01) dec = mk(1'b1, 1'b0, resStore, postCvt, 3'b000, 1'b0);
                 else bad = 1'b1;            // only w and d widths
      opStoreFp: if (funct3[2:1] == 2'b01) dec = mk(1'b0, 1'b0, resStore, postCvt, 3'b000, 1'b0);
                 else bad = 1'b1;
      // fma opCtrl = {not madd, negate product, negate addend}
      opMadd:  dec = mk(1'b1, 1'b0, resPost, postFma, 3'b000, 1'b0);
      opMsub:  dec = mk(1'b1, 1'b0, resPost, postFma, 3'b001, 1'b0);
      opNmsub: dec = mk(1'b1, 1'b0, resPost, postFma, 3'b010, 1'b0);
      opNmadd: dec = mk(1'b1, 1'b0, resPost, postFma, 3'b011, 1'b0);
      opFp: begin
        case (funct5)
          f5Add:  dec = mk(1'b1, 1'b0, resPost, postFma, 3'b110, 1'b0);
          f5Sub:  dec = mk(1'b1, 1'b0, resPost, postFma, 3'b111, 1'b0);
          f5Mul:  dec = mk(1'b1, 1'b0, resPost, postFma, 3'b100, 1'b0);
          f5Div:  dec = mk(1'b1, 1'b0, resPost, postDiv, 3'b000, 1'b1);
          f5Sqrt: dec = mk(1'b1, 1'b0, resPost, postDiv, 3'b001, 1'b1);
          f5Sgnj: if (funct3 <= 3'b010) dec = mk(1'b1, 1'b0, resOther, postCvt, funct3, 1'b0);
                  else bad = 1'b1;           // j, jn, jx
          f5MinMax: begin
            if (funct3 == 3'b000) dec = mk(1'b1, 1'b0, resOther, postCvt, 3'b110, 1'b0);
            else if (funct3 == 3'b001) dec = mk(1'b1, 1'b0, resOther, postCvt, 3'b101, 1'b0);
            else bad = 1'b1;
          end
          f5Cmp: begin
            case (funct3)
              3'b010:  dec = mk(1'b0, 1'b1, resOther, postCvt, 3'b010, 1'b0); // feq
              3'b001:  dec = mk(1'b0, 1'b1, resOther, postCvt, 3'b001, 1'b0); // flt
              3'b000:  dec = mk(1'b0, 1'b1, resOther, postCvt, 3'b011, 1'b0); // fle
              default: bad = 1'b1;
            endcase
          end
          f5ClassMv: begin
            if (funct3 == 3'b001) dec = mk(1'b0, 1'b1, resStore, postCvt, 3'b000, 1'b0);
            else if (!funct3[1]) dec = mk(1'b0, 1'b1, resMove, postCvt, 3'b000, 1'b0);
            else bad = 1'b1;
          end
          // int converts: opCtrl = {int to fp, 64-bit int, signed}
          f5CvtIF: if (fmtOk) dec = mk(1'b1, 1'b0, resPost, postCvt, {1'b1, rs2[1], ~rs2[0]}, 1'b0);
                   else bad = 1'b1;
          f5CvtFI: if (fmtOk) dec = mk(1'b0, 1'b1, resPost, postCvt, {1'b0, rs2[1], ~rs2[0]}, 1'b0);
                   else bad = 1'b1;
          f5CvtFF:  if (fmtOk) dec = mk(1'b1, 1'b0, resPost, postCvt, {2'b00, fmtBits[0]}, 1'b0);
                    else bad = 1'b1;         // opCtrl holds the target fmt
          f5MvToFp: if (fmtOk) dec = mk(1'b1, 1'b0, resOther, postCvt, 3'b011, 1'b0);
                    else bad = 1'b1;
          default: bad = 1'b1;
        endcase
      end
      default: bad = 1'b1;
    endcase
  end

  // rounding mode and format, then the illegal override
  always_comb begin
    ctrlD     = dec;
    ctrlD.frm = (roundModeT'(funct3) == rmDyn) ? frmCsr : roundModeT'(funct3);
    ctrlD.fmt = cvtFF ? fpFmtT'(rs2[0]) : fpFmtT'(fmtBits[0]);  // cvt: source fmt
    if (bad || fsStatus == 2'b00) begin
      ctrlD         = '0;   // no writes, no div
      ctrlD.illegal = 1'b1;
    end
  end

endmodule

// ==== hdl/fpuCtrlPkg.sv ====
package fpuCtrlPkg;

  // divider input queue depth, one credit per slot
  localparam int divCredits = 2;
  localparam int creditW    = $clog2(divCredits + 1);

  // final result select (fp dest / int dest)
  typedef enum logic [1:0] {
    resOther = 2'b00,   // sign inj, min/max, fmv.w.x / compare
    resPost  = 2'b01,   // post-process / convert
    resStore = 2'b10,   // load, store / class
    resMove  = 2'b11    // fmv.x.*
  } resSelT;

  // post-process unit select
  typedef enum logic [1:0] {
    postCvt = 2'b00,
    postDiv = 2'b01,
    postFma = 2'b10
  } postSelT;

  ////////////////////////////////////////////////////////////////////
  // per-stage control words
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  fRegWrite;  // write fp regfile
    logic                  fWriteInt;  // write int regfile
    resSelT                resSel;
    postSelT               postSel;
    logic [2:0]            opCtrl;
    logic                  divStart;   // div or sqrt
    logic                  illegal;
    fpuIsaPkg::roundModeT  frm;        // already resolved, never dyn
    fpuIsaPkg::fpFmtT      fmt;
  } ctrlDT;

  typedef struct packed {
    logic                           fRegWrite;
    logic                           fWriteInt;
    resSelT                         resSel;
    postSelT                        postSel;
    logic [2:0]                     opCtrl;
    logic                           illegal;
    fpuIsaPkg::roundModeT           frm;
    fpuIsaPkg::fpFmtT               fmt;
    logic [fpuIsaPkg::regAdrW-1:0]  adr1;   // rs1
    logic [fpuIsaPkg::regAdrW-1:0]  adr2;   // rs2
    logic [fpuIsaPkg::regAdrW-1:0]  adr3;   // rs3, fma only
    logic                           divOp;  // div/sqrt not yet started
  } ctrlET;

  typedef struct packed {
    logic                  fRegWrite;
    logic                  fWriteInt;
    resSelT                resSel;
    postSelT               postSel;
    logic [2:0]            opCtrl;
    fpuIsaPkg::roundModeT  frm;
    fpuIsaPkg::fpFmtT      fmt;
    logic                  illegal;
  } ctrlMT;

  typedef struct packed {
    logic    fRegWrite;
    resSelT  resSel;
  } ctrlWT;

endpackage

// ==== hdl/fpuIsaPkg.sv ====
package fpuIsaPkg;

  ////////////////////////////////////////////////////////////////////
  // instruction field widths
  ////////////////////////////////////////////////////////////////////

  localparam int opcodeW = 7;
  localparam int funct3W = 3;
  localparam int funct5W = 5;
  localparam int regAdrW = 5;   // rs1/rs2/rs3/rd

  ////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////

  // major opcodes of the fp subset, bits 6:0
  typedef enum logic [opcodeW-1:0] {
    opLoadFp  = 7'b0000111,   // flw, fld
    opStoreFp = 7'b0100111,   // fsw, fsd
    opMadd    = 7'b1000011,
    opMsub    = 7'b1000111,
    opNmsub   = 7'b1001011,
    opNmadd   = 7'b1001111,
    opFp      = 7'b1010011    // everything else, split on funct5
  } fpOpcodeT;

  // funct5 = instr[31:27] under opFp
  // low two funct7 bits carry the format
  typedef enum logic [funct5W-1:0] {
    f5Add     = 5'b00000,
    f5Sub     = 5'b00001,
    f5Mul     = 5'b00010,
    f5Div     = 5'b00011,
    f5Sgnj    = 5'b00100,
    f5MinMax  = 5'b00101,
    f5CvtFF   = 5'b01000,   // fp -> fp, source fmt in rs2
    f5Sqrt    = 5'b01011,
    f5Cmp     = 5'b10100,
    f5CvtFI   = 5'b11000,   // fp -> int
    f5CvtIF   = 5'b11010,   // int -> fp
    f5ClassMv = 5'b11100,   // fclass, fmv.x.*
    f5MvToFp  = 5'b11110    // fmv.*.x
  } fpFunct5T;

  // rounding modes, funct3 or frm csr
  typedef enum logic [funct3W-1:0] {
    rmNe  = 3'b000,   // nearest, ties to even
    rmTz  = 3'b001,   // toward zero
    rmDn  = 3'b010,   // toward -inf
    rmUp  = 3'b011,   // toward +inf
    rmMm  = 3'b100,   // nearest, ties to max magnitude
    rmDyn = 3'b111    // take it from frm csr
  } roundModeT;

  typedef enum logic {
    fmtSingle = 1'b0,
    fmtDouble = 1'b1
  } fpFmtT;

endpackage
